/* design/host_chan_pkg.sv */
// ============================
// Shared types and constants for the host channel shim.
// Every module in the shim refers to these by scoped name.
// ============================
`default_nettype none

package host_chan_pkg;

    // ============================
    // Sizes and limits
    // ============================
    localparam int tid_bits = 9;
    localparam int dw_addr_bits = 16;
    localparam int byte_addr_bits = 18;
    localparam int line_bits = 512;

    // Depth of the read tag queue, which is also the outstanding read limit
    localparam int max_mmio_rd_reqs = 64;
    localparam int tag_ptr_bits = $clog2(max_mmio_rd_reqs);

    // Extra timing registers on each MMIO output toward the accelerator
    localparam int mmio_reg_stages = 1;

    // ============================
    // Message encodings
    // ============================
    typedef enum logic [1:0] {
        kind_mem_rsp = 2'd0,
        kind_mmio_wr = 2'd1,
        kind_mmio_rd = 2'd2
    } msg_kind_t;

    typedef enum logic [1:0] {
        len_4b  = 2'd0,
        len_8b  = 2'd1,
        len_64b = 2'd2
    } mmio_len_t;

    // Incoming host message; narrow MMIO payloads sit in data[63:0]
    typedef struct packed {
        msg_kind_t               kind;
        mmio_len_t               len;
        logic [tid_bits-1:0]     tid;
        logic [dw_addr_bits-1:0] addr;
        logic [line_bits-1:0]    data;
    } host_rx_msg_t;

    // Host memory read response toward the accelerator
    typedef struct packed {
        logic [tid_bits-1:0]  tid;
        logic [line_bits-1:0] data;
    } mem_rsp_t;

    // Decoded MMIO request, address still in dword units
    typedef struct packed {
        logic                    is_rd;
        mmio_len_t               len;
        logic [tid_bits-1:0]     tid;
        logic [dw_addr_bits-1:0] addr;
        logic [63:0]             data;
    } mmio_req_t;

    // ============================
    // Accelerator side payloads
    // ============================
    typedef struct packed {
        logic [byte_addr_bits-1:0] addr;
        logic [63:0]               data;
        logic [7:0]                strb;
    } mmio_wr_t;

    typedef struct packed {
        logic [byte_addr_bits-1:0] addr;
    } mmio_rd_t;

    typedef struct packed {
        logic [byte_addr_bits-1:0] addr;
        logic [line_bits-1:0]      data;
    } wide_wr_t;

    // Per-read context kept until the accelerator answers
    typedef struct packed {
        logic [tid_bits-1:0] tid;
        mmio_len_t           len;
        logic                hi_half;
    } rd_tag_t;

    // Read completion back to the host
    typedef struct packed {
        logic [tid_bits-1:0] tid;
        logic [63:0]         data;
    } host_tx_msg_t;

endpackage

`default_nettype wire

/* design/host_chan_decode.sv */
// ============================
// Front stage of the shim. Registers each host message and sorts it
// into memory response, register MMIO or wide MMIO write.
// ============================
`timescale 1ns/1ps
`default_nettype none

module host_chan_decode (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        rx_valid,
    input  wire host_chan_pkg::host_rx_msg_t rx_msg,
    output logic                             mem_rsp_valid,
    output host_chan_pkg::mem_rsp_t          mem_rsp,
    output logic                             mmio_valid,
    output host_chan_pkg::mmio_req_t         mmio_req,
    output logic                             wide_valid,
    output host_chan_pkg::mmio_req_t         wide_req,
    output logic [host_chan_pkg::line_bits-1:0] wide_data
);

    logic is_mem;
    logic is_wide;
    logic is_mmio;

    // Wide reads are not supported by the host, so only writes use len_64b
    assign is_mem  = (rx_msg.kind == host_chan_pkg::kind_mem_rsp);
    assign is_wide = (rx_msg.kind == host_chan_pkg::kind_mmio_wr) &&
                     (rx_msg.len == host_chan_pkg::len_64b);
    assign is_mmio = ((rx_msg.kind == host_chan_pkg::kind_mmio_wr) ||
                      (rx_msg.kind == host_chan_pkg::kind_mmio_rd)) && !is_wide;

    // Exactly one strobe per accepted message
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rsp_valid <= 1'b0;
            mmio_valid    <= 1'b0;
            wide_valid    <= 1'b0;
        end else begin
            mem_rsp_valid <= rx_valid && is_mem;
            mmio_valid    <= rx_valid && is_mmio;
            wide_valid    <= rx_valid && is_wide;
        end
    end

    // Payloads follow every cycle and are qualified by the strobes above
    always_ff @(posedge clk) begin
        mem_rsp.tid    <= rx_msg.tid;
        mem_rsp.data   <= rx_msg.data;
        mmio_req.is_rd <= (rx_msg.kind == host_chan_pkg::kind_mmio_rd);
        mmio_req.len   <= rx_msg.len;
        mmio_req.tid   <= rx_msg.tid;
        mmio_req.addr  <= rx_msg.addr;
        mmio_req.data  <= rx_msg.data[63:0];
        // The full line travels beside wide_req in wide_data
        wide_req.is_rd <= 1'b0;
        wide_req.len   <= rx_msg.len;
        wide_req.tid   <= rx_msg.tid;
        wide_req.addr  <= rx_msg.addr;
        wide_req.data  <= '0;
        wide_data      <= rx_msg.data;
    end

endmodule

`default_nettype wire

/* design/mmio_execute.sv */
// ============================
// Maps decoded MMIO requests to byte-addressed accelerator strobes.
// Every read leaves a tag in an in-order queue for the result stage.
// ============================
`timescale 1ns/1ps
`default_nettype none

module mmio_execute (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        mmio_valid,
    input  wire host_chan_pkg::mmio_req_t    mmio_req,
    input  wire logic                        wide_valid,
    input  wire host_chan_pkg::mmio_req_t    wide_req,
    input  wire logic [host_chan_pkg::line_bits-1:0] wide_data,
    output logic                             wr_valid,
    output host_chan_pkg::mmio_wr_t          wr,
    output logic                             rd_valid,
    output host_chan_pkg::mmio_rd_t          rd,
    output logic                             wide_wr_valid,
    output host_chan_pkg::wide_wr_t          wide_wr,
    input  wire logic                        tag_pop,
    output host_chan_pkg::rd_tag_t           tag_head,
    output logic                             tag_avail
);

    // ============================
    // Address and strobe mapping
    // ============================
    logic                     is_4b;
    logic                     tag_push;
    host_chan_pkg::mmio_wr_t  wr_next;
    host_chan_pkg::rd_tag_t   tag_next;

    assign is_4b    = (mmio_req.len == host_chan_pkg::len_4b);
    assign tag_push = mmio_valid && mmio_req.is_rd;

    always_comb begin
        // Register port addresses are aligned down to 8 bytes
        wr_next.addr = {mmio_req.addr[15:1], 3'b000};
        // A 4 byte access lands in the half picked by the odd dword bit
        if (is_4b) begin
            wr_next.strb = mmio_req.addr[0] ? 8'hf0 : 8'h0f;
            wr_next.data = {mmio_req.data[31:0], mmio_req.data[31:0]};
        end else begin
            wr_next.strb = 8'hff;
            wr_next.data = mmio_req.data;
        end
        tag_next.tid     = mmio_req.tid;
        tag_next.len     = mmio_req.len;
        tag_next.hi_half = mmio_req.addr[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid      <= 1'b0;
            rd_valid      <= 1'b0;
            wide_wr_valid <= 1'b0;
        end else begin
            wr_valid      <= mmio_valid && !mmio_req.is_rd;
            rd_valid      <= tag_push;
            wide_wr_valid <= wide_valid;
        end
    end

    always_ff @(posedge clk) begin
        wr           <= wr_next;
        rd.addr      <= wr_next.addr;
        // Wide writes are aligned down to a 64 byte line
        wide_wr.addr <= {wide_req.addr[15:4], 6'b000000};
        wide_wr.data <= wide_data;
    end

    // ============================
    // Read tag queue
    // ============================
    host_chan_pkg::rd_tag_t tag_mem [host_chan_pkg::max_mmio_rd_reqs];
    logic [host_chan_pkg::tag_ptr_bits-1:0] wr_ptr;
    logic [host_chan_pkg::tag_ptr_bits-1:0] rd_ptr;
    logic [host_chan_pkg::tag_ptr_bits:0]   count;

    always_ff @(posedge clk) begin
        if (tag_push) begin
            tag_mem[wr_ptr] <= tag_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tag_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tag_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count moves only when exactly one side is active
            case ({tag_push, tag_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign tag_head  = tag_mem[rd_ptr];
    assign tag_avail = (count != '0);

endmodule

`default_nettype wire

/* design/reg_stage_pipe.sv */
// ============================
// Chain of timing registers for any packed payload and its valid strobe.
// With n_stages of zero the payload passes through unregistered.
// ============================
`timescale 1ns/1ps
`default_nettype none

module reg_stage_pipe #(
    parameter type payload_t = logic,
    parameter int  n_stages  = 1
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic in_valid,
    input  wire payload_t in_data,
    output logic      out_valid,
    output payload_t  out_data
);

    if (n_stages == 0) begin : g_bypass
        assign out_valid = in_valid;
        assign out_data  = in_data;
    end else begin : g_stages
        logic     valid_q [n_stages];
        payload_t data_q  [n_stages];

        // Valid strobes shift down the chain and clear on reset
        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < n_stages; i++) begin
                    valid_q[i] <= 1'b0;
                end
            end else begin
                valid_q[0] <= in_valid;
                for (int i = 1; i < n_stages; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        // Payload shifts alongside its strobe
        always_ff @(posedge clk) begin
            data_q[0] <= in_data;
            for (int i = 1; i < n_stages; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end

        assign out_valid = valid_q[n_stages-1];
        assign out_data  = data_q[n_stages-1];
    end

endmodule

`default_nettype wire

/* design/mmio_result.sv */
// ============================
// Builds MMIO read completions for the host. Each accelerator response
// takes the oldest queued tag, in order.
// ============================
`timescale 1ns/1ps
`default_nettype none

module mmio_result (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rd_rsp_valid,
    input  wire logic [63:0]            rd_rsp_data,
    input  wire host_chan_pkg::rd_tag_t tag_head,
    input  wire logic                   tag_avail,
    output logic                        tag_pop,
    output logic                        tx_valid,
    output host_chan_pkg::host_tx_msg_t tx_msg
);

    logic [63:0] rsp_data_sel;

    // ============================
    // Tag matching
    // ============================

    // A response with no tag waiting has no owner and is dropped
    assign tag_pop = rd_rsp_valid && tag_avail;

    // ============================
    // Data selection
    // ============================
    always_comb begin
        if (tag_head.len == host_chan_pkg::len_4b) begin
            // Narrow read returns the addressed half, zero extended
            if (tag_head.hi_half) begin
                rsp_data_sel = {32'b0, rd_rsp_data[63:32]};
            end else begin
                rsp_data_sel = {32'b0, rd_rsp_data[31:0]};
            end
        end else begin
            rsp_data_sel = rd_rsp_data;
        end
    end

    // ============================
    // Completion register
    // ============================
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= tag_pop;
        end
    end

    // Payload is held between completions
    always_ff @(posedge clk) begin
        if (tag_pop) begin
            tx_msg.tid  <= tag_head.tid;
            tx_msg.data <= rsp_data_sel;
        end
    end

endmodule

`default_nettype wire

/* design/host_chan_top.sv */
// ============================
// Top of the host channel shim. Splits host traffic into memory
// responses, a read/write register port and a write-only wide port.
// ============================
`timescale 1ns/1ps
`default_nettype none

module host_chan_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    // Host side
    input  wire logic                        rx_valid,
    input  wire host_chan_pkg::host_rx_msg_t rx_msg,
    output logic                             host_mem_rsp_valid,
    output host_chan_pkg::mem_rsp_t          host_mem_rsp,
    output logic                             tx_valid,
    output host_chan_pkg::host_tx_msg_t      tx_msg,
    // Accelerator side
    output logic                             mmio_wr_valid,
    output host_chan_pkg::mmio_wr_t          mmio_wr,
    output logic                             mmio_rd_valid,
    output host_chan_pkg::mmio_rd_t          mmio_rd,
    output logic                             wide_wr_valid,
    output host_chan_pkg::wide_wr_t          wide_wr,
    input  wire logic                        rd_rsp_valid,
    input  wire logic [63:0]                 rd_rsp_data
);

    logic                                 mmio_valid;
    host_chan_pkg::mmio_req_t             mmio_req;
    logic                                 wide_valid;
    host_chan_pkg::mmio_req_t             wide_req;
    logic [host_chan_pkg::line_bits-1:0]  wide_data;
    logic                                 ex_wr_valid;
    host_chan_pkg::mmio_wr_t              ex_wr;
    logic                                 ex_rd_valid;
    host_chan_pkg::mmio_rd_t              ex_rd;
    logic                                 ex_wide_valid;
    host_chan_pkg::wide_wr_t              ex_wide;
    logic                                 tag_pop;
    host_chan_pkg::rd_tag_t               tag_head;
    logic                                 tag_avail;

    // ============================
    // Decode and execute
    // ============================

    // Memory responses leave straight from the decode registers
    host_chan_decode decode (
        .clk,
        .rst,
        .rx_valid,
        .rx_msg,
        .mem_rsp_valid (host_mem_rsp_valid),
        .mem_rsp       (host_mem_rsp),
        .mmio_valid,
        .mmio_req,
        .wide_valid,
        .wide_req,
        .wide_data
    );

    mmio_execute execute (
        .clk,
        .rst,
        .mmio_valid,
        .mmio_req,
        .wide_valid,
        .wide_req,
        .wide_data,
        .wr_valid      (ex_wr_valid),
        .wr            (ex_wr),
        .rd_valid      (ex_rd_valid),
        .rd            (ex_rd),
        .wide_wr_valid (ex_wide_valid),
        .wide_wr       (ex_wide),
        .tag_pop,
        .tag_head,
        .tag_avail
    );

    // ============================
    // Output timing registers
    // ============================
    reg_stage_pipe #(
        .payload_t (host_chan_pkg::mmio_wr_t),
        .n_stages  (host_chan_pkg::mmio_reg_stages)
    ) pipe_wr (
        .clk,
        .rst,
        .in_valid  (ex_wr_valid),
        .in_data   (ex_wr),
        .out_valid (mmio_wr_valid),
        .out_data  (mmio_wr)
    );

    reg_stage_pipe #(
        .payload_t (host_chan_pkg::mmio_rd_t),
        .n_stages  (host_chan_pkg::mmio_reg_stages)
    ) pipe_rd (
        .clk,
        .rst,
        .in_valid  (ex_rd_valid),
        .in_data   (ex_rd),
        .out_valid (mmio_rd_valid),
        .out_data  (mmio_rd)
    );

    reg_stage_pipe #(
        .payload_t (host_chan_pkg::wide_wr_t),
        .n_stages  (host_chan_pkg::mmio_reg_stages)
    ) pipe_wide (
        .clk,
        .rst,
        .in_valid  (ex_wide_valid),
        .in_data   (ex_wide),
        .out_valid (wide_wr_valid),
        .out_data  (wide_wr)
    );

    // Read completions back toward the host
    mmio_result result (
        .clk,
        .rst,
        .rd_rsp_valid,
        .rd_rsp_data,
        .tag_head,
        .tag_avail,
        .tag_pop,
        .tx_valid,
        .tx_msg
    );

endmodule

`default_nettype wire

/* tests/tb_host_chan_ref.svh */
// ============================
// Reference model and compare task for the host channel testbench.
// Included inside the testbench module body.
// ============================
`ifndef TB_HOST_CHAN_REF_SVH
`define TB_HOST_CHAN_REF_SVH

// Output port that a host message is expected to leave on
typedef enum logic [1:0] {port_mem, port_wr, port_rd, port_wide} out_port_t;

// Expected response for one message where only the field for its port is used
typedef struct packed {
    out_port_t                   port;
    host_chan_pkg::mem_rsp_t     mem;
    host_chan_pkg::mmio_wr_t     wr;
    host_chan_pkg::mmio_rd_t     rd;
    host_chan_pkg::wide_wr_t     wide;
    host_chan_pkg::host_tx_msg_t tx;
} exp_out_t;

// Scoreboard entry with the cycle at which the strobe must show up
typedef struct packed {
    logic [31:0]  due;
    logic [639:0] val;
} exp_item_t;

function automatic exp_out_t expected_out(input host_chan_pkg::host_rx_msg_t m);
    exp_out_t    e;
    logic [17:0] byte_addr;
    logic [63:0] rdata;
    e = '0;
    // Dword address times four gives the byte address
    byte_addr = {m.addr, 2'b00};
    if (m.kind == host_chan_pkg::kind_mem_rsp) begin
        e.port     = port_mem;
        e.mem.tid  = m.tid;
        e.mem.data = m.data;
    end else if (m.kind == host_chan_pkg::kind_mmio_wr && m.len == host_chan_pkg::len_64b) begin
        e.port      = port_wide;
        e.wide.addr = byte_addr & ~18'h3f;
        e.wide.data = m.data;
    end else if (m.kind == host_chan_pkg::kind_mmio_wr) begin
        e.port    = port_wr;
        e.wr.addr = byte_addr & ~18'h7;
        if (m.len == host_chan_pkg::len_4b) begin
            // Odd dword lands in the upper half and data is mirrored in both
            e.wr.strb = 8'h0f << (4 * m.addr[0]);
            e.wr.data = {2{m.data[31:0]}};
        end else begin
            e.wr.strb = 8'hff;
            e.wr.data = m.data[63:0];
        end
    end else begin
        e.port    = port_rd;
        e.rd.addr = byte_addr & ~18'h7;
        rdata     = rd_model_data(e.rd.addr);
        e.tx.tid  = m.tid;
        if (m.len == host_chan_pkg::len_4b) begin
            // The addressed half is shifted down and the upper half cleared
            e.tx.data = (rdata >> (32 * m.addr[0])) & 64'h0000_0000_ffff_ffff;
        end else begin
            e.tx.data = rdata;
        end
    end
    return e;
endfunction

task automatic check_value(input string name, input logic [639:0] exp_v,
                           input logic [639:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
        err_count++;
        $display("ERROR %s: expected %0h actual %0h", name, exp_v, act_v);
    end
endtask

`endif

/* tests/tb_host_chan.sv */
// ============================
// Testbench for the host channel shim. Drives host messages, models the
// accelerator register port and scores every output strobe.
// ============================
`timescale 1ns/1ps
`default_nettype none

module tb_host_chan;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        rx_valid;
    host_chan_pkg::host_rx_msg_t rx_msg;
    logic                        host_mem_rsp_valid;
    host_chan_pkg::mem_rsp_t     host_mem_rsp;
    logic                        tx_valid;
    host_chan_pkg::host_tx_msg_t tx_msg;
    logic                        mmio_wr_valid;
    host_chan_pkg::mmio_wr_t     mmio_wr;
    logic                        mmio_rd_valid;
    host_chan_pkg::mmio_rd_t     mmio_rd;
    logic                        wide_wr_valid;
    host_chan_pkg::wide_wr_t     wide_wr;
    logic                        rd_rsp_valid = 1'b0;
    logic [63:0]                 rd_rsp_data = '0;

    int    cyc = 0;
    int    err_count = 0;
    int    check_count = 0;
    int    err_mark = 0;
    string cur_test = "reset";
    // Stimulus length of the reset, idle, memory, write, wide, read and mix tests
    int    timeout_cycles = (8 + 20 + 40 + 30 + 10 + 16 + 300) * 4 + 200;

    // Accelerator register contents as a fixed function of the byte address
    // The two halves of a word always differ
    function automatic logic [63:0] rd_model_data(input logic [17:0] addr);
        return {addr, 14'h02b5, ~addr, 14'h01c3};
    endfunction

    `include "tb_host_chan_ref.svh"

    // Pending read on the accelerator model and the cycle it may answer
    typedef struct packed {
        logic [31:0] ready;
        logic [17:0] addr;
    } acc_req_t;

    exp_item_t                   q_mem[$];
    exp_item_t                   q_wr[$];
    exp_item_t                   q_rd[$];
    exp_item_t                   q_wide[$];
    exp_item_t                   q_tx[$];
    host_chan_pkg::host_tx_msg_t pend_tx[$];
    acc_req_t                    acc_q[$];

    host_chan_top uut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        wait (cyc >= timeout_cycles);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic exp_item_t make_item(input int due, input logic [639:0] val);
        exp_item_t item;
        item.due = due;
        item.val = val;
        return item;
    endfunction

    // ============================
    // Scoreboard
    // ============================
    task automatic match_port(input string name, input logic valid, input logic [639:0] act,
                              ref exp_item_t q[$]);
        exp_item_t item;
        string     tag;
        tag = {cur_test, " ", name};
        if (valid === 1'b1) begin
            if (q.size() == 0) begin
                err_count++;
                $display("Unexpected strobe on %s in test %s at cycle %0d", name, cur_test, cyc);
            end else begin
                item = q.pop_front();
                check_value({tag, " cycle"}, 640'(item.due), 640'(cyc));
                check_value(tag, item.val, act);
            end
        end else if (valid !== 1'b0) begin
            err_count++;
            $display("Strobe on %s is unknown at cycle %0d", name, cyc);
        end
        // An entry past its cycle means the strobe never came
        if (q.size() != 0 && q[0].due < cyc) begin
            err_count++;
            $display("Missing strobe on %s in test %s, due at cycle %0d",
                     name, cur_test, q[0].due);
            void'(q.pop_front());
        end
    endtask

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        match_port("host_mem_rsp", host_mem_rsp_valid, 640'(host_mem_rsp), q_mem);
        match_port("mmio_wr", mmio_wr_valid, 640'(mmio_wr), q_wr);
        match_port("mmio_rd", mmio_rd_valid, 640'(mmio_rd), q_rd);
        match_port("wide_wr", wide_wr_valid, 640'(wide_wr), q_wide);
        match_port("tx", tx_valid, 640'(tx_msg), q_tx);
        if (mmio_rd_valid === 1'b1) begin
            acc_q.push_back(acc_req_t'{ready: cyc + ($urandom % 6), addr: mmio_rd.addr});
        end
    end

    // Accelerator model answers reads in order and at most one per cycle
    always @(posedge clk) begin
        rd_rsp_valid <= 1'b0;
        if (acc_q.size() != 0 && acc_q[0].ready <= cyc) begin
            rd_rsp_valid <= 1'b1;
            rd_rsp_data  <= rd_model_data(acc_q[0].addr);
            void'(acc_q.pop_front());
            if (pend_tx.size() != 0) begin
                q_tx.push_back(make_item(cyc + 2, 640'(pend_tx.pop_front())));
            end
        end
    end

    // ============================
    // Stimulus
    // ============================
    function automatic logic [511:0] rand_line();
        logic [511:0] v;
        for (int i = 0; i < 16; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic host_chan_pkg::host_rx_msg_t make_msg(
        input host_chan_pkg::msg_kind_t kind, input host_chan_pkg::mmio_len_t len,
        input logic [15:0] addr);
        host_chan_pkg::host_rx_msg_t m;
        m.kind = kind;
        m.len  = len;
        m.tid  = 9'($urandom);
        m.addr = addr;
        m.data = rand_line();
        return m;
    endfunction

    // Memory path takes 1 cycle
    // MMIO path takes 2 cycles plus the output stages
    task automatic send_msg(input host_chan_pkg::host_rx_msg_t m);
        exp_out_t e;
        int       mmio_due;
        e = expected_out(m);
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_msg   <= m;
        mmio_due = cyc + 3 + host_chan_pkg::mmio_reg_stages;
        case (e.port)
            port_mem:  q_mem.push_back(make_item(cyc + 2, 640'(e.mem)));
            port_wr:   q_wr.push_back(make_item(mmio_due, 640'(e.wr)));
            port_wide: q_wide.push_back(make_item(mmio_due, 640'(e.wide)));
            default: begin
                q_rd.push_back(make_item(mmio_due, 640'(e.rd)));
                pend_tx.push_back(e.tx);
            end
        endcase
    endtask

    task automatic finish_test();
        @(posedge clk);
        rx_valid <= 1'b0;
        while (q_mem.size() + q_wr.size() + q_rd.size() + q_wide.size() + q_tx.size()
               + pend_tx.size() + acc_q.size() != 0) begin
            @(posedge clk);
        end
        // A few quiet cycles catch strobes that should not exist
        repeat (4) @(posedge clk);
        $display("Test %s finished with %0d errors", cur_test, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin
        host_chan_pkg::msg_kind_t kind;
        host_chan_pkg::mmio_len_t len;
        void'($urandom(32'hc832));
        rst      = 1'b1;
        rx_valid = 1'b0;
        rx_msg   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        cur_test = "idle";
        repeat (20) @(posedge clk);
        finish_test();
        cur_test = "mem_rsp";
        for (int i = 0; i < 40; i++) begin
            send_msg(make_msg(host_chan_pkg::kind_mem_rsp, host_chan_pkg::len_4b,
                              16'($urandom)));
        end
        finish_test();
        // Every third write is 8 bytes and the rest alternate even and odd dwords
        cur_test = "reg_write";
        for (int i = 0; i < 30; i++) begin
            len = (i % 3 == 2) ? host_chan_pkg::len_8b : host_chan_pkg::len_4b;
            send_msg(make_msg(host_chan_pkg::kind_mmio_wr, len, {15'($urandom), 1'(i)}));
        end
        finish_test();
        cur_test = "wide_write";
        for (int i = 0; i < 10; i++) begin
            send_msg(make_msg(host_chan_pkg::kind_mmio_wr, host_chan_pkg::len_64b,
                              16'($urandom)));
        end
        finish_test();
        cur_test = "read_burst";
        for (int i = 0; i < 16; i++) begin
            len = ($urandom % 2 == 0) ? host_chan_pkg::len_4b : host_chan_pkg::len_8b;
            send_msg(make_msg(host_chan_pkg::kind_mmio_rd, len, 16'($urandom)));
        end
        finish_test();
        // Wide reads are outside the host contract and never generated
        cur_test = "random_mix";
        for (int i = 0; i < 300; i++) begin
            kind = host_chan_pkg::msg_kind_t'($urandom % 3);
            if (kind == host_chan_pkg::kind_mmio_rd) begin
                len = host_chan_pkg::mmio_len_t'($urandom % 2);
            end else begin
                len = host_chan_pkg::mmio_len_t'($urandom % 3);
            end
            send_msg(make_msg(kind, len, 16'($urandom)));
        end
        finish_test();
        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tests
design/host_chan_pkg.sv
design/host_chan_decode.sv
design/mmio_execute.sv
design/reg_stage_pipe.sv
design/mmio_result.sv
design/host_chan_top.sv
tests/tb_host_chan.sv

/* Makefile */
# Verilator build and run for the host channel shim testbench.
# The run passes only if the log holds the testbench pass line.

TOP = tb_host_chan

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f
	verilator --lint-only --top-module host_chan_top design/host_chan_pkg.sv \
		design/host_chan_decode.sv design/mmio_execute.sv design/reg_stage_pipe.sv \
		design/mmio_result.sv design/host_chan_top.sv

clean:
	rm -rf obj_dir sim.log
